/* list.f */
rtl/board_pkg.sv
rtl/event_pkg.sv
rtl/sideband_sampler.sv
rtl/event_fifo.sv
rtl/event_reporter.sv
rtl/sideband_top.sv
sim/sideband_checker.sv
sim/tb_top.sv

/* rtl/board_pkg.sv */
// Sideband pin vector types and default timing constants for the board inputs
package board_pkg;

    // Two buttons in the upper bits, two switches below
    typedef logic [3:0] switch_vec_t;

    // a interrupt_n, a mod_prs_n, b interrupt_n, b mod_prs_n
    // All active low, idle high
    typedef logic [3:0] cage_vec_t;

    // Flops per input synchronizer
    localparam int SYNC_STAGES = 2;

    // Cycles between debounce samples
    localparam int DEFAULT_DEBOUNCE_RATE = 250000;

    // Equal samples needed before a switch bit is taken as stable
    localparam int DEFAULT_DEBOUNCE_DEPTH = 4;

    // Change records held between sampler and reporter
    localparam int DEFAULT_FIFO_DEPTH = 8;

endpackage

/* rtl/event_fifo.sv */
// Circular buffer for change records with a saturating drop counter
`timescale 1ns/100ps

module event_fifo
    import event_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic        pcie_clk,
    input  logic        rst_i,
    input  logic        rec_wr_i,
    input  event_rec_t  rec_data_i,
    input  logic        rec_rd_i,
    output logic        rec_empty_o,
    output event_rec_t  rec_data_o,
    output drop_count_t overflow_count_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    event_rec_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    // Pointers wrap at FIFO_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full        = (count_q == CNT_W'(FIFO_DEPTH));
    assign rec_empty_o = (count_q == '0);

    assign do_wr = rec_wr_i && !full;
    assign do_rd = rec_rd_i && !rec_empty_o;

    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_rd) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= rec_data_i;
        end
    end

    // Head of queue, first word fall through
    assign rec_data_o = mem[rd_ptr_q];

    // Records arriving while full are lost
    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            overflow_count_o <= '0;
        end else if (rec_wr_i && full && overflow_count_o != '1) begin
            overflow_count_o <= overflow_count_o + 1'b1;
        end
    end

endmodule

/* rtl/event_pkg.sv */
// Change record layout, cause codes, drop counter type and reporter states
package event_pkg;

    import board_pkg::*;

    // Bit 1 switch change, bit 0 cage change
    typedef logic [1:0] cause_t;

    localparam cause_t CAUSE_NONE   = 2'b00;
    localparam cause_t CAUSE_SWITCH = 2'b10;
    localparam cause_t CAUSE_CAGE   = 2'b01;

    // {cause, switch state, cage state}, MSB first
    typedef logic [$bits(cause_t) + $bits(switch_vec_t) + $bits(cage_vec_t) - 1:0] event_rec_t;

    // Saturates at all ones
    typedef logic [7:0] drop_count_t;

    typedef enum logic [1:0] {
        idle          = 2'd0,
        wait_ack_high = 2'd1,
        wait_ack_low  = 2'd2
    } report_state_t;

endpackage

/* rtl/event_reporter.sv */
// Four-phase req/ack sender that hands change records to the host
`timescale 1ns/100ps

module event_reporter
    import event_pkg::*;
(
    input  logic       pcie_clk,
    input  logic       rst_i,
    input  logic       rec_empty_i,
    input  event_rec_t rec_data_i,
    output logic       rec_rd_o,
    output logic       evt_req_o,
    output event_rec_t evt_data_o,
    input  logic       evt_ack_i
);

    report_state_t state_q;

    // Pop when a record waits and the previous handshake has fully closed
    assign rec_rd_o = (state_q == idle || state_q == wait_ack_low) &&
                      !rec_empty_i && !evt_ack_i;

    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            state_q <= idle;
        end else begin
            case (state_q)
                idle: begin
                    if (rec_rd_o) begin
                        state_q <= wait_ack_high;
                    end
                end
                wait_ack_high: begin
                    if (evt_ack_i) begin
                        state_q <= wait_ack_low;
                    end
                end
                wait_ack_low: begin
                    // Back to back records skip idle
                    if (rec_rd_o) begin
                        state_q <= wait_ack_high;
                    end else if (!evt_ack_i) begin
                        state_q <= idle;
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    // Held stable for the whole request phase
    always_ff @(posedge pcie_clk) begin
        if (rec_rd_o) begin
            evt_data_o <= rec_data_i;
        end
    end

    assign evt_req_o = (state_q == wait_ack_high);

endmodule

/* rtl/sideband_sampler.sv */
// Sideband sampler with input synchronizers, switch debouncer and change detector
`timescale 1ns/100ps

module sideband_sampler
    import board_pkg::*;
    import event_pkg::*;
#(
    parameter int DEBOUNCE_RATE  = DEFAULT_DEBOUNCE_RATE,
    parameter int DEBOUNCE_DEPTH = DEFAULT_DEBOUNCE_DEPTH
) (
    input  logic        pcie_clk,
    input  logic        rst_i,
    input  switch_vec_t switch_i,
    input  cage_vec_t   cage_i,
    output switch_vec_t switch_state_o,
    output logic        rec_wr_o,
    output event_rec_t  rec_data_o
);

    localparam int SW_W   = $bits(switch_vec_t);
    localparam int CAGE_W = $bits(cage_vec_t);
    localparam int IN_W   = SW_W + CAGE_W;
    localparam int RATE_W = $clog2(DEBOUNCE_RATE + 1);

    // Switches idle low, cage pins idle high
    localparam logic [IN_W-1:0] SYNC_RST = {switch_vec_t'('0), cage_vec_t'('1)};

    logic [SYNC_STAGES-1:0][IN_W-1:0] sync_q;
    switch_vec_t sw_sync;
    cage_vec_t   cage_sync;

    logic [RATE_W-1:0] rate_cnt_q;
    logic              sample_tick;

    logic [SW_W-1:0][DEBOUNCE_DEPTH-1:0] hist_q;
    switch_vec_t sw_stable_q;

    switch_vec_t sw_prev_q;
    cage_vec_t   cage_prev_q;
    logic        sw_diff;
    logic        cage_diff;
    cause_t      cause;

    // Switches and cage pins share one synchronizer chain
    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            sync_q <= {SYNC_STAGES{SYNC_RST}};
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], switch_i, cage_i};
        end
    end

    assign {sw_sync, cage_sync} = sync_q[SYNC_STAGES-1];

    // Debounce sample strobe
    assign sample_tick = (rate_cnt_q == RATE_W'(DEBOUNCE_RATE - 1));

    always_ff @(posedge pcie_clk) begin
        if (rst_i || sample_tick) begin
            rate_cnt_q <= '0;
        end else begin
            rate_cnt_q <= rate_cnt_q + 1'b1;
        end
    end

    // A bit only moves once its whole history agrees
    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            hist_q      <= '0;
            sw_stable_q <= '0;
        end else begin
            for (int i = 0; i < SW_W; i++) begin
                if (sample_tick) begin
                    hist_q[i] <= (hist_q[i] << 1) | DEBOUNCE_DEPTH'(sw_sync[i]);
                end
                if (&hist_q[i]) begin
                    sw_stable_q[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    sw_stable_q[i] <= 1'b0;
                end
            end
        end
    end

    // Change detection against last reported state
    assign sw_diff   = (sw_stable_q != sw_prev_q);
    assign cage_diff = (cage_sync != cage_prev_q);

    assign cause = (sw_diff ? CAUSE_SWITCH : CAUSE_NONE) |
                   (cage_diff ? CAUSE_CAGE : CAUSE_NONE);

    always_ff @(posedge pcie_clk) begin
        if (rst_i) begin
            sw_prev_q   <= '0;
            cage_prev_q <= '1;
            rec_wr_o    <= 1'b0;
        end else begin
            sw_prev_q   <= sw_stable_q;
            cage_prev_q <= cage_sync;
            rec_wr_o    <= sw_diff || cage_diff;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (sw_diff || cage_diff) begin
            rec_data_o <= {cause, sw_stable_q, cage_sync};
        end
    end

    // LEDs switch together with the record write
    assign switch_state_o = sw_prev_q;

endmodule

/* rtl/sideband_top.sv */
// Sideband top level joining sampler, record FIFO and host reporter
`timescale 1ns/100ps

module sideband_top
    import board_pkg::*;
    import event_pkg::*;
#(
    parameter int DEBOUNCE_RATE  = DEFAULT_DEBOUNCE_RATE,
    parameter int DEBOUNCE_DEPTH = DEFAULT_DEBOUNCE_DEPTH,
    parameter int FIFO_DEPTH     = DEFAULT_FIFO_DEPTH
) (
    input  logic        pcie_clk,
    input  logic        rst_i,
    input  switch_vec_t switch_i,
    input  cage_vec_t   cage_i,
    output switch_vec_t led_o,
    output logic        evt_req_o,
    output event_rec_t  evt_data_o,
    input  logic        evt_ack_i,
    output drop_count_t overflow_count_o
);

    logic       rec_wr;
    event_rec_t rec_wr_data;
    logic       rec_rd;
    logic       rec_empty;
    event_rec_t rec_head;

    sideband_sampler #(
        .DEBOUNCE_RATE  (DEBOUNCE_RATE),
        .DEBOUNCE_DEPTH (DEBOUNCE_DEPTH)
    ) sideband_sampler_inst (
        .pcie_clk       (pcie_clk),
        .rst_i          (rst_i),
        .switch_i       (switch_i),
        .cage_i         (cage_i),
        .switch_state_o (led_o),
        .rec_wr_o       (rec_wr),
        .rec_data_o     (rec_wr_data)
    );

    event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) event_fifo_inst (
        .pcie_clk         (pcie_clk),
        .rst_i            (rst_i),
        .rec_wr_i         (rec_wr),
        .rec_data_i       (rec_wr_data),
        .rec_rd_i         (rec_rd),
        .rec_empty_o      (rec_empty),
        .rec_data_o       (rec_head),
        .overflow_count_o (overflow_count_o)
    );

    event_reporter event_reporter_inst (
        .pcie_clk    (pcie_clk),
        .rst_i       (rst_i),
        .rec_empty_i (rec_empty),
        .rec_data_i  (rec_head),
        .rec_rd_o    (rec_rd),
        .evt_req_o   (evt_req_o),
        .evt_data_o  (evt_data_o),
        .evt_ack_i   (evt_ack_i)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the sideband testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_top -o vtb_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
    exit 0
else
    exit 1
fi

/* sim/sideband_checker.sv */
// Sideband checker for handshake rules, record order, LED state and drop count
`timescale 1ns/100ps

module sideband_checker
    import board_pkg::*;
    import event_pkg::*;
(
    input  logic        pcie_clk,
    input  logic        rst_i,
    input  switch_vec_t led_i,
    input  logic        evt_req_i,
    input  event_rec_t  evt_data_i,
    input  logic        evt_ack_i,
    input  drop_count_t overflow_count_i
);

    event_rec_t  exp_q[$];
    switch_vec_t led_q[$];
    int          error_count  = 0;
    int          check_count  = 0;
    int          record_count = 0;

    logic        prev_req  = 1'b0;
    logic        prev_ack  = 1'b0;
    event_rec_t  prev_data = '0;
    switch_vec_t prev_led  = '0;

    task automatic expect_record(input cause_t cause, input switch_vec_t sw,
                                 input cage_vec_t cage);
        exp_q.push_back({cause, sw, cage});
        // LEDs move only on switch records
        if (cause[1]) begin
            led_q.push_back(sw);
        end
    endtask

    function automatic int pending_records();
        return exp_q.size();
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        error_count++;
        $display("error: time %0t signal %s expected %h actual %h", $time, name, exp_v, act_v);
    endtask

    // Sample mid-cycle where all DUT outputs are settled
    always @(negedge pcie_clk) begin
        if (!rst_i) begin
            if (!prev_req && evt_req_i && evt_ack_i) begin
                error_count++;
                $display("Request raised at time %0t while acknowledge was still high", $time);
            end
            if (prev_req && evt_req_i) begin
                check_count++;
                if (evt_data_i != prev_data) begin
                    value_error("evt_data_o", 32'(prev_data), 32'(evt_data_i));
                end
            end
            if (prev_req && !evt_req_i) begin
                record_count++;
                if (!prev_ack) begin
                    error_count++;
                    $display("Request dropped at time %0t without acknowledge", $time);
                end
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected record %h delivered at time %0t", prev_data, $time);
                end else begin
                    check_count++;
                    if (prev_data != exp_q[0]) begin
                        value_error("evt_data_o", 32'(exp_q[0]), 32'(prev_data));
                    end
                    void'(exp_q.pop_front());
                end
            end
            if (led_i != prev_led) begin
                if (led_q.size() == 0) begin
                    error_count++;
                    $display("led_o changed at time %0t with no switch record due", $time);
                end else begin
                    check_count++;
                    if (led_i != led_q[0]) begin
                        value_error("led_o", 32'(led_q[0]), 32'(led_i));
                    end
                    void'(led_q.pop_front());
                end
            end
        end
        prev_req  <= evt_req_i;
        prev_ack  <= evt_ack_i;
        prev_data <= evt_data_i;
        prev_led  <= led_i;
    end

    task automatic final_check(input drop_count_t exp_drops);
        check_count++;
        if (overflow_count_i != exp_drops) begin
            value_error("overflow_count_o", 32'(exp_drops), 32'(overflow_count_i));
        end
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d expected records were never delivered", exp_q.size());
        end
        if (led_q.size() != 0) begin
            error_count++;
            $display("%0d expected LED changes never happened", led_q.size());
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, records %0d, errors %0d", check_count, record_count, error_count);
    endtask

endmodule

/* sim/sideband_stimulus.txt */
// Columns, hex: type _ hold or count _ ack mode or cause _ switch _ cage
// Type 1 step (mode 0 normal, 1 withheld), 2 expected record, 3 expected drops, F end
1_014_0_0_F
1_028_0_1_F
2_000_2_1_F
1_006_0_9_F
1_01E_0_1_F
1_00A_0_1_7
2_000_1_1_7
1_00A_0_1_5
2_000_1_1_5
1_00A_0_1_F
2_000_1_1_F
1_011_0_3_F
1_028_0_3_D
2_000_3_3_D
1_008_1_3_E
1_008_1_3_F
1_008_1_3_E
1_008_1_3_F
1_008_1_3_E
1_008_1_3_F
1_008_1_3_E
1_008_1_3_F
1_008_1_3_E
1_008_1_3_F
1_008_1_3_E
1_008_1_3_F
2_000_1_3_E
2_000_1_3_F
2_000_1_3_E
2_000_1_3_F
2_000_1_3_E
2_000_1_3_F
2_000_1_3_E
2_000_1_3_F
2_000_1_3_E
1_0C8_0_3_F
3_003_0_0_0
F_000_0_0_0

/* sim/tb_top.sv */
// Testbench top with clock, reset, file stimulus, random ack pacing and timeout
`timescale 1ns/100ps

module tb_top;
    import board_pkg::*;
    import event_pkg::*;

    logic        pcie_clk = 1'b0;
    logic        rst_i;
    switch_vec_t switch_i;
    cage_vec_t   cage_i;
    switch_vec_t led_o;
    logic        evt_req_o;
    event_rec_t  evt_data_o;
    logic        evt_ack_i;
    drop_count_t overflow_count_o;

    // type, hold, mode or cause, switch, cage
    logic [27:0] stim_mem [0:63];
    logic        withhold;
    logic [15:0] lfsr_state = 16'd53101;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    always #5 pcie_clk = ~pcie_clk;

    sideband_top #(
        .DEBOUNCE_RATE  (4),
        .DEBOUNCE_DEPTH (4),
        .FIFO_DEPTH     (8)
    ) sideband_top_inst (
        .pcie_clk         (pcie_clk),
        .rst_i            (rst_i),
        .switch_i         (switch_i),
        .cage_i           (cage_i),
        .led_o            (led_o),
        .evt_req_o        (evt_req_o),
        .evt_data_o       (evt_data_o),
        .evt_ack_i        (evt_ack_i),
        .overflow_count_o (overflow_count_o)
    );

    sideband_checker checker_inst (
        .pcie_clk         (pcie_clk),
        .rst_i            (rst_i),
        .led_i            (led_o),
        .evt_req_i        (evt_req_o),
        .evt_data_i       (evt_data_o),
        .evt_ack_i        (evt_ack_i),
        .overflow_count_i (overflow_count_o)
    );

    // Galois LFSR with taps at 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int take_delay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++) begin
            d = d | (int'(lfsr_state[0]) << i);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return d;
    endfunction

    // Host side of the four-phase handshake
    initial begin
        int delay;
        forever begin
            @(negedge pcie_clk);
            if (evt_req_o && !evt_ack_i && !withhold) begin
                delay = take_delay();
                repeat (delay) @(posedge pcie_clk);
                @(posedge pcie_clk);
                evt_ack_i <= 1'b1;
                do begin
                    @(negedge pcie_clk);
                end while (evt_req_o);
                delay = take_delay();
                repeat (delay) @(posedge pcie_clk);
                @(posedge pcie_clk);
                evt_ack_i <= 1'b0;
            end
        end
    end

    always @(posedge pcie_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles without reaching the end", cycle_count);
            checker_inst.report_counts();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int          hold_sum;
        drop_count_t exp_drops;
        int          idx;
        rst_i     = 1'b1;
        switch_i  = '0;
        cage_i    = '1;
        evt_ack_i = 1'b0;
        withhold  = 1'b0;
        hold_sum  = 0;
        exp_drops = '0;

        $readmemh("sim/sideband_stimulus.txt", stim_mem);
        idx = 0;
        while (idx < 64 && stim_mem[idx][27:24] != 4'hF) begin
            case (stim_mem[idx][27:24])
                4'h1: hold_sum += int'(stim_mem[idx][23:12]);
                4'h2: checker_inst.expect_record(stim_mem[idx][9:8], stim_mem[idx][7:4],
                                                 stim_mem[idx][3:0]);
                4'h3: exp_drops = drop_count_t'(stim_mem[idx][23:12]);
                default: ;
            endcase
            idx++;
        end
        cycle_limit = 2 * hold_sum + 1000;

        repeat (4) @(posedge pcie_clk);
        rst_i <= 1'b0;

        idx = 0;
        while (idx < 64 && stim_mem[idx][27:24] != 4'hF) begin
            if (stim_mem[idx][27:24] == 4'h1) begin
                switch_i <= stim_mem[idx][7:4];
                cage_i   <= stim_mem[idx][3:0];
                withhold <= stim_mem[idx][8];
                repeat (int'(stim_mem[idx][23:12])) @(posedge pcie_clk);
            end
            idx++;
        end

        // Let the host finish every outstanding handshake
        while (checker_inst.pending_records() != 0 || evt_req_o || evt_ack_i) begin
            @(posedge pcie_clk);
        end

        checker_inst.final_check(exp_drops);
        checker_inst.report_counts();
        if (checker_inst.error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
